//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int addrBits = 32;
    localparam int dataBits = 32;

    typedef logic [addrBits-1:0] addrT;
    typedef logic [dataBits-1:0] dataT;

    // access length in bytes, only 1, 2 or 4 are legal
    typedef logic [2:0] accLenT;

    typedef enum logic {
        load  = 1'b0,
        store = 1'b1
    } lsKindT;

    localparam logic [6:0] opJal = 7'b1101111;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // same word, read raw or as J-type fields
    typedef union packed {
        logic [31:0] raw;
        jTypeT       jType;
    } instWordT;

endpackage

`default_nettype wire

//--- memBusPkg.sv
`default_nettype none

package memBusPkg;

    typedef logic [7:0] byteT;

    typedef enum logic {
        read  = 1'b0,
        write = 1'b1
    } rwT;

    // who holds the ram port
    typedef enum logic [1:0] {
        none  = 2'b00,
        data  = 2'b01,
        fetch = 2'b10
    } ownerT;

endpackage

`default_nettype wire

//--- byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam #(
    parameter int unsigned ramAddrBits = 10
) (
    input  wire                     clk,
    input  wire  memBusPkg::rwT     memRw,
    input  wire  cpuPkg::addrT      memAddr,
    input  wire  memBusPkg::byteT   memWdata,
    output memBusPkg::byteT         memRdata
);

    localparam int unsigned depth = 2 ** ramAddrBits;

    memBusPkg::byteT mem [depth] = '{default: '0};

    logic [ramAddrBits-1:0] ramIdx;

    // upper address bits are ignored, the array wraps
    assign ramIdx = memAddr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (memRw == memBusPkg::write) begin
            mem[ramIdx] <= memWdata;
        end
        // read returns old contents on a same-address write
        memRdata <= mem[ramIdx];
    end

endmodule

`default_nettype wire

//--- memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rdy,
    input  wire                      ioBufferFull,

    // data requester
    input  wire                      dataEn,
    input  wire  cpuPkg::lsKindT     dataKind,
    input  wire  cpuPkg::accLenT     dataLen,
    input  wire  cpuPkg::addrT       dataAddr,
    input  wire  cpuPkg::dataT       dataWdata,
    output logic                     dataDone,
    output cpuPkg::dataT             dataRdata,

    // instruction fetch
    input  wire                      fetchEn,
    input  wire  cpuPkg::addrT       fetchAddr,
    output logic                     fetchDone,
    output cpuPkg::instWordT         fetchWord,

    // ram port
    input  wire  memBusPkg::byteT    memRdata,
    output memBusPkg::rwT            memRw,
    output cpuPkg::addrT             memAddr,
    output memBusPkg::byteT          memWdata,

    output memBusPkg::ownerT         busyOwner
);

    memBusPkg::ownerT owner;
    memBusPkg::ownerT curOwner;
    logic [2:0]       idx;
    logic [2:0]       rdIdx;
    logic             stall;
    logic             curEn;
    logic             isWrite;
    logic             doneNow;
    cpuPkg::addrT     reqAddr;
    cpuPkg::accLenT   reqLen;
    cpuPkg::accLenT   doneIdx;
    cpuPkg::dataT     shiftReg;
    logic [4:0]       dropBits;

    assign stall = ioBufferFull || !rdy;

    // data wins over fetch, but only when idle
    always_comb begin
        if (owner != memBusPkg::none) begin
            curOwner = owner;
        end else if (dataEn) begin
            curOwner = memBusPkg::data;
        end else if (fetchEn) begin
            curOwner = memBusPkg::fetch;
        end else begin
            curOwner = memBusPkg::none;
        end
    end

    always_comb begin
        curEn   = 1'b0;
        reqAddr = fetchAddr;
        reqLen  = 3'd4;
        isWrite = 1'b0;
        case (curOwner)
            memBusPkg::data: begin
                curEn   = dataEn;
                reqAddr = dataAddr;
                reqLen  = dataLen;
                isWrite = (dataKind == cpuPkg::store);
            end
            memBusPkg::fetch: begin
                curEn = fetchEn;
            end
            default: begin
                curEn = 1'b0;
            end
        endcase
    end

    // reads need one extra cycle for the ram latency
    assign doneIdx = isWrite ? reqLen : reqLen + 3'd1;
    assign doneNow = !stall && curEn && (idx == doneIdx);

    // on a stall, point back at the byte still in flight so that
    // memRdata is valid again in the first cycle after the stall
    assign rdIdx = (stall && idx != 3'd0) ? idx - 3'd1 : idx;

    assign memAddr  = reqAddr + cpuPkg::addrT'(rdIdx);
    assign memWdata = dataWdata[{idx[1:0], 3'b000} +: 8];
    assign memRw    = (!stall && curEn && isWrite && idx < reqLen) ?
                      memBusPkg::write : memBusPkg::read;

    assign dataDone  = doneNow && (curOwner == memBusPkg::data);
    assign fetchDone = doneNow && (curOwner == memBusPkg::fetch);
    assign busyOwner = owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= memBusPkg::none;
            idx   <= '0;
        end else if (!stall) begin
            if (!curEn || doneNow) begin
                // done or aborted, back to idle
                owner <= memBusPkg::none;
                idx   <= '0;
            end else begin
                owner <= curOwner;
                idx   <= idx + 3'd1;
            end
        end
    end

    // bytes enter at the top, so byte 0 ends up lowest
    always_ff @(posedge clk) begin
        if (!stall && curEn && !isWrite && idx != 3'd0 && idx <= reqLen) begin
            shiftReg <= {memRdata, shiftReg[31:8]};
        end
    end

    always_comb begin
        case (dataLen)
            3'd1:    dropBits = 5'd24;
            3'd2:    dropBits = 5'd16;
            default: dropBits = 5'd0;
        endcase
    end

    // shifting down also zero-extends
    assign dataRdata     = shiftReg >> dropBits;
    assign fetchWord.raw = shiftReg;

    assert property (@(posedge clk) disable iff (rst)
        !(dataDone && fetchDone));

    // owner only leaves through done or abort
    assert property (@(posedge clk) disable iff (rst)
        (owner != memBusPkg::none && curEn && !doneNow) |=> owner == $past(owner));

    assert property (@(posedge clk) disable iff (rst)
        dataEn |-> dataLen inside {3'd1, 3'd2, 3'd4});

endmodule

`default_nettype wire

//--- instFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instFetch #(
    parameter cpuPkg::addrT resetPc = 32'h0
) (
    input  wire                      clk,
    input  wire                      rst,

    // memCtrl side
    input  wire                      fetchDone,
    input  wire  cpuPkg::instWordT   fetchWord,
    output logic                     fetchEn,
    output cpuPkg::addrT             fetchAddr,

    // consumer side
    input  wire                      instReady,
    output logic                     instValid,
    output cpuPkg::instWordT         instWord,
    output cpuPkg::addrT             instPc
);

    cpuPkg::addrT pc;
    cpuPkg::addrT jImm;
    cpuPkg::addrT nextPc;

    // J immediate, sign-extended, bit 0 always zero
    assign jImm = {{11{fetchWord.jType.imm20}},
                   fetchWord.jType.imm20,
                   fetchWord.jType.imm19to12,
                   fetchWord.jType.imm11,
                   fetchWord.jType.imm10to1,
                   1'b0};

    assign nextPc = (fetchWord.jType.opcode == cpuPkg::opJal) ? pc + jImm : pc + 32'd4;

    assign fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= resetPc;
            fetchEn   <= 1'b0;
            instValid <= 1'b0;
        end else if (fetchDone) begin
            fetchEn   <= 1'b0;
            instValid <= 1'b1;
            pc        <= nextPc;
        end else if (instValid) begin
            // hold the word, no fetch until it is taken
            if (instReady) begin
                instValid <= 1'b0;
                fetchEn   <= 1'b1;
            end
        end else begin
            fetchEn <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instWord <= fetchWord;
            instPc   <= pc;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        fetchEn |-> fetchAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- memSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsys #(
    parameter int unsigned  ramAddrBits = 10,
    parameter cpuPkg::addrT resetPc     = 32'h0
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rdy,
    input  wire                      ioBufferFull,

    input  wire                      dataEn,
    input  wire  cpuPkg::lsKindT     dataKind,
    input  wire  cpuPkg::accLenT     dataLen,
    input  wire  cpuPkg::addrT       dataAddr,
    input  wire  cpuPkg::dataT       dataWdata,
    output logic                     dataDone,
    output cpuPkg::dataT             dataRdata,

    input  wire                      instReady,
    output logic                     instValid,
    output cpuPkg::instWordT         instWord,
    output cpuPkg::addrT             instPc,

    output memBusPkg::ownerT         busyOwner
);

    logic              fetchEn;
    logic              fetchDone;
    cpuPkg::addrT      fetchAddr;
    cpuPkg::instWordT  fetchWord;
    memBusPkg::rwT     memRw;
    cpuPkg::addrT      memAddr;
    cpuPkg::addrT      ramAddr;
    memBusPkg::byteT   memWdata;
    memBusPkg::byteT   memRdata;

    // only the bits that reach the ram array
    assign ramAddr = cpuPkg::addrT'(memAddr[ramAddrBits-1:0]);

    instFetch #(
        .resetPc (resetPc)
    ) instFetch_i (
        .clk       (clk),
        .rst       (rst),
        .fetchDone (fetchDone),
        .fetchWord (fetchWord),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .instReady (instReady),
        .instValid (instValid),
        .instWord  (instWord),
        .instPc    (instPc)
    );

    memCtrl memCtrl_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataKind     (dataKind),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchWord    (fetchWord),
        .memRdata     (memRdata),
        .memRw        (memRw),
        .memAddr      (memAddr),
        .memWdata     (memWdata),
        .busyOwner    (busyOwner)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) byteRam_i (
        .clk      (clk),
        .memRw    (memRw),
        .memAddr  (ramAddr),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

endmodule

`default_nettype wire

//--- tbMemSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemSubsys;

    localparam int unsigned  ramAddrBits = 10;
    localparam cpuPkg::addrT resetPc     = 32'h100;
    localparam int           resetCycles = 16;
    localparam int           opLimit     = 40;

    localparam int kindStore   = 0;
    localparam int kindLoad    = 1;
    localparam int kindFetch   = 2;
    localparam int kindRelease = 3;

    logic              clk = 1'b0;
    logic              rst;
    logic              rdy;
    logic              ioBufferFull;
    logic              dataEn;
    cpuPkg::lsKindT    dataKind;
    cpuPkg::accLenT    dataLen;
    cpuPkg::addrT      dataAddr;
    cpuPkg::dataT      dataWdata;
    logic              instReady;
    logic              dataDone;
    cpuPkg::dataT      dataRdata;
    logic              instValid;
    cpuPkg::instWordT  instWord;
    cpuPkg::addrT      instPc;
    memBusPkg::ownerT  busyOwner;

    int errors     = 0;
    int cycles     = 0;
    int cycleLimit = 0;

    int               opKind[$];
    logic [31:0]      opArgA[$];
    logic [31:0]      opArgB[$];
    logic [31:0]      opArgC[$];
    cpuPkg::addrT     pcSeen[$];
    cpuPkg::instWordT wordSeen[$];

    memSubsys #(
        .ramAddrBits (ramAddrBits),
        .resetPc     (resetPc)
    ) memSubsys_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataKind     (dataKind),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .instReady    (instReady),
        .instValid    (instValid),
        .instWord     (instWord),
        .instPc       (instPc),
        .busyOwner    (busyOwner)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout, run stopped after %0d cycles with %0d errors", cycles, errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // every word the consumer takes, in order
    always @(posedge clk) begin
        if (!rst && instValid && instReady) begin
            pcSeen.push_back(instPc);
            wordSeen.push_back(instWord);
        end
    end

    task automatic checkData(input string name, input cpuPkg::dataT got,
            input cpuPkg::dataT exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkInst(input string name, input cpuPkg::instWordT got,
            input cpuPkg::instWordT exp);
        if (got.raw !== exp.raw) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got.raw, exp.raw);
        end
    endtask

    task automatic checkPc(input string name, input cpuPkg::addrT got,
            input cpuPkg::addrT exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkOwner(input string name, input memBusPkg::ownerT got,
            input memBusPkg::ownerT exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // one rising edge, with a random stall for the coming cycle
    task automatic nextEdge();
        int r;
        @(posedge clk);
        r = $urandom % 8;
        rdy          <= (r != 0);
        ioBufferFull <= (r == 1);
    endtask

    task automatic readOps();
        int               fd;
        int               n;
        logic [8*128-1:0] lineBuf;
        logic [8*16-1:0]  opName;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        fd = $fopen("memSubsysInput.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the data file memSubsysInput.txt");
        end else begin
            while (!$feof(fd)) begin
                lineBuf = '0;
                opName  = '0;
                a = '0;
                b = '0;
                c = '0;
                n = $fgets(lineBuf, fd);
                if (n > 0) begin
                    n = $sscanf(lineBuf, "%s %h %h %h", opName, a, b, c);
                end
                if (n <= 0 || opName == "#") begin
                    // blank or comment line
                end else if (opName == "store" || opName == "load" ||
                        opName == "fetchExpect" || opName == "release") begin
                    if (opName == "store") opKind.push_back(kindStore);
                    else if (opName == "load") opKind.push_back(kindLoad);
                    else if (opName == "fetchExpect") opKind.push_back(kindFetch);
                    else opKind.push_back(kindRelease);
                    opArgA.push_back(a);
                    opArgB.push_back(b);
                    opArgC.push_back(c);
                end else begin
                    errors++;
                    $display("data file holds an unknown operation: %0s", opName);
                end
            end
            $fclose(fd);
        end
    endtask

    // cycle 0 is the first idle, unstalled cycle with the request seen
    task automatic runData(input cpuPkg::lsKindT kind, input cpuPkg::addrT addr,
            input cpuPkg::accLenT len, input cpuPkg::dataT value);
        int waited;
        int count;
        int expLat;
        bit started;
        bit gotDone;
        bit stallNow;
        waited  = 0;
        count   = 0;
        started = 1'b0;
        gotDone = 1'b0;
        expLat  = (kind == cpuPkg::store) ? int'(len) : int'(len) + 1;
        nextEdge();
        dataEn    <= 1'b1;
        dataKind  <= kind;
        dataLen   <= len;
        dataAddr  <= addr;
        dataWdata <= (kind == cpuPkg::store) ? value : '0;
        while (!gotDone && waited < opLimit) begin
            @(negedge clk);
            waited++;
            stallNow = !rdy || ioBufferFull;
            if (started) begin
                checkOwner("busyOwner", busyOwner, memBusPkg::data);
            end
            if (!stallNow) begin
                if (started) count++;
                else if (busyOwner == memBusPkg::none) started = 1'b1;
            end
            if (dataDone) begin
                gotDone = 1'b1;
                if (!started || count != expLat) begin
                    errors++;
                    $display("dataDone at 0x%h came after %0d cycles, expected %0d",
                             addr, count, expLat);
                end
                if (kind == cpuPkg::load) begin
                    checkData("dataRdata", dataRdata, value);
                end
            end else begin
                nextEdge();
            end
        end
        if (!gotDone) begin
            errors++;
            $display("no dataDone for the %0s at 0x%h within %0d cycles",
                     (kind == cpuPkg::store) ? "store" : "load", addr, opLimit);
        end
        nextEdge();
        dataEn <= 1'b0;
    endtask

    task automatic expectFetch(input cpuPkg::addrT pc, input cpuPkg::instWordT word);
        int               waited;
        cpuPkg::addrT     gotPc;
        cpuPkg::instWordT gotWord;
        waited = 0;
        @(negedge clk);
        while (pcSeen.size() == 0 && waited < opLimit) begin
            nextEdge();
            @(negedge clk);
            waited++;
        end
        if (pcSeen.size() == 0) begin
            errors++;
            $display("no instruction was taken within %0d cycles, expected pc 0x%h",
                     opLimit, pc);
        end else begin
            gotPc   = pcSeen.pop_front();
            gotWord = wordSeen.pop_front();
            checkPc("instPc", gotPc, pc);
            checkInst("instWord", gotWord, word);
        end
    endtask

    initial begin : mainFlow
        int               seed;
        int               gap;
        cpuPkg::instWordT expWord;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        dataEn       = 1'b0;
        dataKind     = cpuPkg::load;
        dataLen      = 3'd4;
        dataAddr     = '0;
        dataWdata    = '0;
        instReady    = 1'b0;
        seed = $urandom(78);
        readOps();
        cycleLimit = opKind.size() * opLimit + resetCycles;

        repeat (resetCycles - 1) @(posedge clk);
        @(negedge clk);
        checkOwner("busyOwner", busyOwner, memBusPkg::none);
        if (dataDone || instValid) begin
            errors++;
            $display("dataDone or instValid is high during reset");
        end
        @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < opKind.size(); i++) begin
            gap = $urandom % 3;
            repeat (gap) nextEdge();
            case (opKind[i])
                kindStore: runData(cpuPkg::store, opArgA[i], opArgB[i][2:0], opArgC[i]);
                kindLoad:  runData(cpuPkg::load, opArgA[i], opArgB[i][2:0], opArgC[i]);
                kindFetch: begin
                    expWord.raw = opArgB[i];
                    expectFetch(opArgA[i], expWord);
                end
                default: begin
                    nextEdge();
                    instReady <= 1'b1;
                end
            endcase
        end

        $display("run complete, %0d operations, %0d errors", opKind.size(), errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
cpuPkg.sv
memBusPkg.sv
byteRam.sv
memCtrl.sv
instFetch.sv
memSubsys.sv
tbMemSubsys.sv

//--- memSubsysInput.txt
# store addr len data / load addr len expected data, zero-extended by len
# fetchExpect pc word / release raises instReady, all values hex
store 00000010 4 44332211
load 00000010 4 44332211
load 00000010 1 00000011
load 00000011 2 00003322
load 00000013 1 00000044
store 00000012 1 000000aa
load 00000010 4 44aa2211
load 00000014 1 00000000
load 0000000f 1 00000000
store 00000011 2 0000c0de
load 00000010 4 44c0de11
load 00000012 2 000044c0
store 00000020 2 12345678
load 00000020 4 00005678
store 00000030 4 a5a5a5a5
store 00000031 1 0000003c
load 00000030 4 a5a53ca5
load 00000032 2 0000a5a5
store 00000104 4 00100093
store 00000108 4 008000ef
store 0000010c 4 deadbeef
store 00000110 2 0000f06f
store 00000112 2 0000ff9f
load 00000110 4 ff9ff06f
release
fetchExpect 00000100 00000000
fetchExpect 00000104 00100093
store 00000200 4 cafef00d
fetchExpect 00000108 008000ef
load 00000200 2 0000f00d
load 00000202 1 000000fe
fetchExpect 00000110 ff9ff06f
store 00000203 1 00000011
load 00000200 4 11fef00d
fetchExpect 00000108 008000ef
load 00000010 4 44c0de11
fetchExpect 00000110 ff9ff06f
load 0000010c 4 deadbeef
fetchExpect 00000108 008000ef
